//--- rtl/isa_pkg.sv
package isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [4:0] reg_idx_t;

    // major opcodes of the kept rv32 base set
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_PASS_IMM,  // lui
        OP_PC_IMM,    // auipc
        OP_JAL,       // link ops, rd gets pc + 4
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LOAD,
        OP_STORE,
        OP_HALT,
        OP_ILLEGAL
    } alu_op_e;

    // same code as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

endpackage

//--- rtl/core_pkg.sv
package core_pkg;

    import isa_pkg::*;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;
        mem_size_e  size;
        logic       wen;
        word_t      wdata;  // already on its byte lane
        byte_mask_t wmask;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } bus_resp_t;

    typedef struct packed {
        alu_op_e   op;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;
        mem_size_e size;
        logic      load_signed;
        logic      writes_rd;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
    } decoded_t;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_FETCH,
        EXECUTE,
        WAIT_MEM,
        HALTED
    } seq_state_e;

endpackage

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import isa_pkg::*, core_pkg::*; #(
    parameter int REG_ADDR_WIDTH = 4
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wen_i,
    input  reg_idx_t waddr_i,
    input  word_t    wdata_i,
    input  reg_idx_t raddr1_i,
    input  reg_idx_t raddr2_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);

    localparam int NUM_REGS = 2 ** REG_ADDR_WIDTH;

    word_t                     regs [NUM_REGS];
    logic [REG_ADDR_WIDTH-1:0] waddr;
    logic [REG_ADDR_WIDTH-1:0] raddr1;
    logic [REG_ADDR_WIDTH-1:0] raddr2;

    // rv32e, upper index bit dropped
    assign waddr  = waddr_i[REG_ADDR_WIDTH-1:0];
    assign raddr1 = raddr1_i[REG_ADDR_WIDTH-1:0];
    assign raddr2 = raddr2_i[REG_ADDR_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr != '0) begin
            regs[waddr] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1 == '0) ? '0 : regs[raddr1];  // x0 hardwired
    assign rdata2_o = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*, core_pkg::*; (
    input  word_t    inst_i,
    output decoded_t dec_o
);

    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // r-type leaves imm at zero and i-type reads x0 as rs2,
    // so the execute unit can OR the two into its second operand
    always_comb begin
        dec_o      = '0;
        dec_o.op   = OP_ILLEGAL;
        dec_o.rd   = inst_i[11:7];
        dec_o.rs1  = inst_i[19:15];
        dec_o.rs2  = inst_i[24:20];
        dec_o.size = MEM_WORD;
        case (opcode)
            OPC_LUI: begin
                dec_o.op  = OP_PASS_IMM;
                dec_o.imm = imm_u;
            end
            OPC_AUIPC: begin
                dec_o.op  = OP_PC_IMM;
                dec_o.imm = imm_u;
            end
            OPC_JAL: begin
                dec_o.op  = OP_JAL;
                dec_o.imm = imm_j;
            end
            OPC_JALR: begin
                dec_o.imm = imm_i;
                if (funct3 == 3'b000) dec_o.op = OP_JALR;
            end
            OPC_BRANCH: begin
                dec_o.imm = imm_b;
                case (funct3)
                    3'b000: dec_o.op = OP_BEQ;
                    3'b001: dec_o.op = OP_BNE;
                    3'b100: dec_o.op = OP_BLT;
                    3'b101: dec_o.op = OP_BGE;
                    3'b110: dec_o.op = OP_BLTU;
                    3'b111: dec_o.op = OP_BGEU;
                    default: dec_o.op = OP_ILLEGAL;
                endcase
                dec_o.is_branch = (dec_o.op != OP_ILLEGAL);
            end
            OPC_LOAD: begin
                dec_o.imm         = imm_i;
                dec_o.load_signed = !funct3[2];  // lbu and lhu have bit 2 set
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    dec_o.op      = OP_LOAD;
                    dec_o.is_load = 1'b1;
                    dec_o.size    = mem_size_e'(funct3[1:0]);
                end
            end
            OPC_STORE: begin
                dec_o.imm = imm_s;
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    dec_o.op       = OP_STORE;
                    dec_o.is_store = 1'b1;
                    dec_o.size     = mem_size_e'(funct3[1:0]);
                end
            end
            OPC_OP_IMM: begin
                dec_o.imm = imm_i;  // shamt sits in imm[4:0]
                dec_o.rs2 = '0;
                case (funct3)
                    3'b000: dec_o.op = OP_ADD;
                    3'b010: dec_o.op = OP_SLT;
                    3'b011: dec_o.op = OP_SLTU;
                    3'b100: dec_o.op = OP_XOR;
                    3'b110: dec_o.op = OP_OR;
                    3'b111: dec_o.op = OP_AND;
                    3'b001: if (funct7 == 7'b0000000) dec_o.op = OP_SLL;
                    default: begin
                        if (funct7 == 7'b0000000) dec_o.op = OP_SRL;
                        else if (funct7 == 7'b0100000) dec_o.op = OP_SRA;
                    end
                endcase
            end
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: dec_o.op = OP_ADD;
                        3'b001: dec_o.op = OP_SLL;
                        3'b010: dec_o.op = OP_SLT;
                        3'b011: dec_o.op = OP_SLTU;
                        3'b100: dec_o.op = OP_XOR;
                        3'b101: dec_o.op = OP_SRL;
                        3'b110: dec_o.op = OP_OR;
                        default: dec_o.op = OP_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) dec_o.op = OP_SUB;
                    else if (funct3 == 3'b101) dec_o.op = OP_SRA;
                end
            end
            OPC_SYSTEM: begin
                if (inst_i == INST_EBREAK) dec_o.op = OP_HALT;
            end
            default: dec_o.op = OP_ILLEGAL;
        endcase
        dec_o.writes_rd = !(dec_o.is_store || dec_o.is_branch ||
                            dec_o.op == OP_HALT || dec_o.op == OP_ILLEGAL);
    end

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import isa_pkg::*, core_pkg::*; (
    input  decoded_t dec_i,
    input  word_t    pc_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    output word_t    alu_result_o,
    output word_t    next_pc_o,
    output word_t    mem_addr_o
);

    word_t      op_b;
    logic [4:0] shamt;
    word_t      pc_plus4;
    word_t      pc_target;
    word_t      rs1_sum;
    logic       cmp_true;

    // one of rs2 and imm is always zero here
    assign op_b  = rs2_data_i | dec_i.imm;
    assign shamt = op_b[4:0];

    assign pc_plus4  = pc_i + 32'd4;
    assign pc_target = pc_i + dec_i.imm;  // branch, jal and auipc
    assign rs1_sum   = rs1_data_i + dec_i.imm;  // data address and jalr

    assign mem_addr_o = rs1_sum;

    always_comb begin
        case (dec_i.op)
            OP_ADD:      alu_result_o = rs1_data_i + op_b;
            OP_SUB:      alu_result_o = rs1_data_i - op_b;
            OP_AND:      alu_result_o = rs1_data_i & op_b;
            OP_OR:       alu_result_o = rs1_data_i | op_b;
            OP_XOR:      alu_result_o = rs1_data_i ^ op_b;
            OP_SLL:      alu_result_o = rs1_data_i << shamt;
            OP_SRL:      alu_result_o = rs1_data_i >> shamt;
            OP_SRA:      alu_result_o = $signed(rs1_data_i) >>> shamt;
            OP_SLT:      alu_result_o = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
            OP_SLTU:     alu_result_o = {31'b0, rs1_data_i < op_b};
            OP_PASS_IMM: alu_result_o = dec_i.imm;
            OP_PC_IMM:   alu_result_o = pc_target;
            OP_JAL,
            OP_JALR:     alu_result_o = pc_plus4;  // link value
            default:     alu_result_o = '0;
        endcase
    end

    always_comb begin
        case (dec_i.op)
            OP_BEQ:  cmp_true = (rs1_data_i == rs2_data_i);
            OP_BNE:  cmp_true = (rs1_data_i != rs2_data_i);
            OP_BLT:  cmp_true = $signed(rs1_data_i) < $signed(rs2_data_i);
            OP_BGE:  cmp_true = $signed(rs1_data_i) >= $signed(rs2_data_i);
            OP_BLTU: cmp_true = rs1_data_i < rs2_data_i;
            OP_BGEU: cmp_true = rs1_data_i >= rs2_data_i;
            default: cmp_true = 1'b0;
        endcase
    end

    always_comb begin
        if ((dec_i.is_branch && cmp_true) || dec_i.op == OP_JAL) begin
            next_pc_o = pc_target;
        end else if (dec_i.op == OP_JALR) begin
            next_pc_o = {rs1_sum[31:1], 1'b0};
        end else begin
            next_pc_o = pc_plus4;  // also illegal words
        end
    end

endmodule

//--- rtl/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import isa_pkg::*, core_pkg::*; (
    input  decoded_t  dec_i,
    input  word_t     mem_addr_i,
    input  word_t     rs2_data_i,
    input  bus_resp_t lsu_resp_i,
    output mem_req_t  store_req_o,
    output word_t     load_data_o
);

    logic [1:0] offset;
    byte_mask_t size_mask;
    word_t      store_data;
    word_t      load_word;

    assign offset = mem_addr_i[1:0];

    always_comb begin
        case (dec_i.size)
            MEM_BYTE: begin
                size_mask  = 4'b0001;
                store_data = {24'b0, rs2_data_i[7:0]};
            end
            MEM_HALF: begin
                size_mask  = 4'b0011;
                store_data = {16'b0, rs2_data_i[15:0]};
            end
            default: begin
                size_mask  = 4'b1111;
                store_data = rs2_data_i;
            end
        endcase
    end

    // the sequencer adds the strobe
    assign store_req_o.valid = 1'b0;
    assign store_req_o.addr  = mem_addr_i;
    assign store_req_o.size  = dec_i.size;
    assign store_req_o.wen   = dec_i.is_store;
    assign store_req_o.wdata = store_data << {offset, 3'b000};
    assign store_req_o.wmask = size_mask << offset;

    // bus returns the aligned word, bring the addressed lane down to bit 0
    assign load_word = lsu_resp_i.rdata >> {offset, 3'b000};

    always_comb begin
        case (dec_i.size)
            MEM_BYTE: load_data_o = {{24{dec_i.load_signed & load_word[7]}}, load_word[7:0]};
            MEM_HALF: load_data_o = {{16{dec_i.load_signed & load_word[15]}}, load_word[15:0]};
            default:  load_data_o = load_word;
        endcase
    end

endmodule

//--- rtl/core_sequencer.sv
`timescale 1ns/1ps

module core_sequencer import isa_pkg::*, core_pkg::*; #(
    parameter word_t RESET_PC = 32'h3000_0000
) (
    input  logic       clock,
    input  logic       reset,
    input  bus_resp_t  ifu_resp_i,
    input  bus_resp_t  lsu_resp_i,
    input  decoded_t   dec_i,
    input  word_t      next_pc_i,
    input  word_t      alu_result_i,
    input  word_t      load_data_i,
    input  mem_req_t   store_req_i,
    output word_t      inst_o,
    output word_t      pc_o,
    output fetch_req_t ifu_req_o,
    output mem_req_t   lsu_req_o,
    output logic       rf_wen_o,
    output word_t      rf_wdata_o,
    output logic       halt_o
);

    seq_state_e state_q;
    word_t      pc_q;
    word_t      inst_q;
    logic       fetch_strobe_q;  // high in the first WAIT_FETCH cycle
    logic       is_mem;
    logic       is_halt;
    logic       commit;

    assign is_mem  = dec_i.is_load | dec_i.is_store;
    assign is_halt = (dec_i.op == OP_HALT);

    // retire point, either straight from EXECUTE or on the data response
    assign commit = (state_q == EXECUTE && !is_mem && !is_halt) ||
                    (state_q == WAIT_MEM && lsu_resp_i.valid);

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q        <= FETCH;
            pc_q           <= RESET_PC;
            fetch_strobe_q <= 1'b0;
        end else begin
            fetch_strobe_q <= 1'b0;
            if (commit) begin
                pc_q <= next_pc_i;
            end
            case (state_q)
                FETCH: begin  // only reached out of reset
                    fetch_strobe_q <= 1'b1;
                    state_q        <= WAIT_FETCH;
                end
                WAIT_FETCH: begin
                    if (ifu_resp_i.valid) begin
                        state_q <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (is_halt) begin
                        state_q <= HALTED;
                    end else if (is_mem) begin
                        state_q <= WAIT_MEM;  // lsu strobe goes out this cycle
                    end else begin
                        fetch_strobe_q <= 1'b1;
                        state_q        <= WAIT_FETCH;
                    end
                end
                WAIT_MEM: begin
                    if (lsu_resp_i.valid) begin
                        fetch_strobe_q <= 1'b1;
                        state_q        <= WAIT_FETCH;
                    end
                end
                HALTED: state_q <= HALTED;  // left only by reset
                default: state_q <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == WAIT_FETCH && ifu_resp_i.valid) begin
            inst_q <= ifu_resp_i.rdata;
        end
    end

    assign inst_o = inst_q;
    assign pc_o   = pc_q;

    assign ifu_req_o.valid = fetch_strobe_q;
    assign ifu_req_o.addr  = pc_q;

    always_comb begin
        lsu_req_o       = store_req_i;
        lsu_req_o.valid = (state_q == EXECUTE) && is_mem;
    end

    assign rf_wen_o   = commit && dec_i.writes_rd;
    assign rf_wdata_o = dec_i.is_load ? load_data_i : alu_result_i;
    assign halt_o     = (state_q == HALTED);

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core import core_pkg::*; #(
    parameter word_t RESET_PC       = 32'h3000_0000,
    parameter int    REG_ADDR_WIDTH = 4
) (
    input  logic       clock,
    input  logic       reset,
    output fetch_req_t ifu_req_o,
    input  bus_resp_t  ifu_resp_i,
    output mem_req_t   lsu_req_o,
    input  bus_resp_t  lsu_resp_i,
    output logic       halt_o
);

    word_t    inst;
    word_t    pc;
    decoded_t dec;
    word_t    next_pc;
    word_t    alu_result;
    word_t    mem_addr;
    word_t    load_data;
    mem_req_t store_req;
    logic     rf_wen;
    word_t    rf_wdata;
    word_t    rs1_data;
    word_t    rs2_data;

    core_sequencer #(
        .RESET_PC(RESET_PC)
    ) u_sequencer (
        .clock(clock),
        .reset(reset),
        .ifu_resp_i(ifu_resp_i),
        .lsu_resp_i(lsu_resp_i),
        .dec_i(dec),
        .next_pc_i(next_pc),
        .alu_result_i(alu_result),
        .load_data_i(load_data),
        .store_req_i(store_req),
        .inst_o(inst),
        .pc_o(pc),
        .ifu_req_o(ifu_req_o),
        .lsu_req_o(lsu_req_o),
        .rf_wen_o(rf_wen),
        .rf_wdata_o(rf_wdata),
        .halt_o(halt_o)
    );

    inst_decoder u_decoder (
        .inst_i(inst),
        .dec_o(dec)
    );

    execute_unit u_execute (
        .dec_i(dec),
        .pc_i(pc),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .alu_result_o(alu_result),
        .next_pc_o(next_pc),
        .mem_addr_o(mem_addr)
    );

    load_store_unit u_lsu (
        .dec_i(dec),
        .mem_addr_i(mem_addr),
        .rs2_data_i(rs2_data),
        .lsu_resp_i(lsu_resp_i),
        .store_req_o(store_req),
        .load_data_o(load_data)
    );

    reg_file #(
        .REG_ADDR_WIDTH(REG_ADDR_WIDTH)
    ) u_reg_file (
        .clock(clock),
        .reset(reset),
        .wen_i(rf_wen),
        .waddr_i(dec.rd),
        .wdata_i(rf_wdata),
        .raddr1_i(dec.rs1),
        .raddr2_i(dec.rs2),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

endmodule

//--- verif/tb_memory.sv
`timescale 1ns/1ps

module tb_memory import core_pkg::*; #(
    parameter word_t MEM_BASE  = 32'h3000_0000,
    parameter int    MEM_WORDS = 2048,
    parameter int    MAX_LAT   = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  fetch_req_t ifu_req_i,
    output bus_resp_t  ifu_resp_o,
    input  mem_req_t   lsu_req_i,
    output bus_resp_t  lsu_resp_o
);

    word_t      mem [MEM_WORDS];
    logic       ifu_strobe;
    word_t      ifu_addr;
    logic       lsu_strobe;
    mem_req_t   lsu_req;
    int         ifu_wait;
    int         lsu_wait;
    word_t      ifu_data;
    word_t      lsu_data;

    // every word starts as the inverse of its own byte address
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = ~(MEM_BASE + 32'(i) * 32'd4);
        end
        ifu_resp_o = '0;
        lsu_resp_o = '0;
        ifu_wait   = 0;
        lsu_wait   = 0;
        ifu_data   = '0;
        lsu_data   = '0;
    end

    function automatic int word_index(input word_t addr);
        return int'(addr[12:2]);  // window of 2048 words
    endfunction

    always @(posedge clock) begin
        // requests are taken as they were before the edge
        ifu_strobe = ifu_req_i.valid;
        ifu_addr   = ifu_req_i.addr;
        lsu_strobe = lsu_req_i.valid;
        lsu_req    = lsu_req_i;
        #1;
        ifu_resp_o = '0;  // one-cycle response pulse
        lsu_resp_o = '0;
        if (reset) begin
            ifu_wait = 0;
            lsu_wait = 0;
        end else begin
            if (ifu_strobe) begin
                ifu_wait = 1 + int'($urandom % MAX_LAT);
                ifu_data = mem[word_index(ifu_addr)];
            end
            if (lsu_strobe) begin
                lsu_wait = 1 + int'($urandom % MAX_LAT);
                if (lsu_req.wen) begin
                    for (int b = 0; b < 4; b++) begin
                        if (lsu_req.wmask[b]) begin
                            mem[word_index(lsu_req.addr)][8*b +: 8] = lsu_req.wdata[8*b +: 8];
                        end
                    end
                end
                lsu_data = mem[word_index(lsu_req.addr)];
            end
            if (ifu_wait != 0) begin
                ifu_wait = ifu_wait - 1;
                if (ifu_wait == 0) begin
                    ifu_resp_o.valid = 1'b1;
                    ifu_resp_o.rdata = ifu_data;
                end
            end
            if (lsu_wait != 0) begin
                lsu_wait = lsu_wait - 1;
                if (lsu_wait == 0) begin
                    lsu_resp_o.valid = 1'b1;
                    lsu_resp_o.rdata = lsu_data;
                end
            end
        end
    end

endmodule

//--- verif/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props (
    input logic clock,
    input logic reset,
    input logic ifu_valid_i,
    input logic lsu_valid_i,
    input logic halt_i
);

    ifu_pulse: assert property (@(posedge clock) disable iff (reset)
        ifu_valid_i |=> !ifu_valid_i)
        else $error("fetch strobe held longer than one cycle");

    lsu_pulse: assert property (@(posedge clock) disable iff (reset)
        lsu_valid_i |=> !lsu_valid_i)
        else $error("data strobe held longer than one cycle");

    one_port: assert property (@(posedge clock) disable iff (reset)
        !(ifu_valid_i && lsu_valid_i))
        else $error("fetch and data requested in the same cycle");

    halt_sticky: assert property (@(posedge clock) disable iff (reset)
        halt_i |=> halt_i)
        else $error("halt dropped outside reset");

    quiet_halt: assert property (@(posedge clock) disable iff (reset)
        halt_i |-> !(ifu_valid_i || lsu_valid_i))
        else $error("request issued while halted");

endmodule

bind rv_core rv_core_props u_props (
    .clock(clock),
    .reset(reset),
    .ifu_valid_i(ifu_req_o.valid),
    .lsu_valid_i(lsu_req_o.valid),
    .halt_i(halt_o)
);

//--- verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import isa_pkg::*, core_pkg::*;;

    localparam word_t RESET_PC  = 32'h3000_0000;
    localparam int    MAX_LAT   = 4;
    localparam int    VEC_WORDS = 128;

    logic       clock;
    logic       reset;
    fetch_req_t ifu_req;
    bus_resp_t  ifu_resp;
    mem_req_t   lsu_req;
    bus_resp_t  lsu_resp;
    logic       halt;

    word_t vectors [VEC_WORDS];
    int    prog_count;
    int    exec_count;
    int    store_count;
    int    store_idx;
    int    cycle_limit;
    int    cycles;

    rv_core #(
        .RESET_PC(RESET_PC),
        .REG_ADDR_WIDTH(4)
    ) UUT (
        .clock(clock),
        .reset(reset),
        .ifu_req_o(ifu_req),
        .ifu_resp_i(ifu_resp),
        .lsu_req_o(lsu_req),
        .lsu_resp_i(lsu_resp),
        .halt_o(halt)
    );

    tb_memory #(
        .MEM_BASE(RESET_PC),
        .MAX_LAT(MAX_LAT)
    ) u_memory (
        .clock(clock),
        .reset(reset),
        .ifu_req_i(ifu_req),
        .ifu_resp_o(ifu_resp),
        .lsu_req_i(lsu_req),
        .lsu_resp_o(lsu_resp)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    // access width follows from how many lanes the mask marks
    function automatic word_t size_of_mask(input word_t mask);
        int lanes;
        lanes = $countones(mask);
        if (lanes == 1) begin
            return word_t'(MEM_BYTE);
        end else if (lanes == 2) begin
            return word_t'(MEM_HALF);
        end
        return word_t'(MEM_WORD);
    endfunction

    // data writes sampled at mid-cycle
    always @(negedge clock) begin
        int rec;
        if (!reset && lsu_req.valid && lsu_req.wen) begin
            if (store_idx >= store_count) begin
                stop_on_error($sformatf("store to %h beyond the expected %0d stores",
                                        lsu_req.addr, store_count));
            end else begin
                rec = 3 + prog_count + 3 * store_idx;
                check_value($sformatf("lsu_req.addr[%0d]", store_idx), lsu_req.addr,
                            vectors[rec]);
                check_value($sformatf("lsu_req.wdata[%0d]", store_idx), lsu_req.wdata,
                            vectors[rec+1]);
                check_value($sformatf("lsu_req.wmask[%0d]", store_idx),
                            {28'b0, lsu_req.wmask}, vectors[rec+2]);
                check_value($sformatf("lsu_req.size[%0d]", store_idx),
                            {30'b0, lsu_req.size}, size_of_mask(vectors[rec+2]));
                store_idx = store_idx + 1;
            end
        end
    end

    initial begin
        void'($urandom(87481));
        reset     = 1'b1;
        store_idx = 0;
        cycles    = 0;
        $readmemh("verif/rv_core_vectors.txt", vectors);
        prog_count  = int'(vectors[0]);
        exec_count  = int'(vectors[1]);
        store_count = int'(vectors[2]);
        cycle_limit = exec_count * (2 * MAX_LAT + 4) + 100;

        repeat (2) @(posedge clock);
        for (int i = 0; i < prog_count; i++) begin
            u_memory.mem[i] = vectors[3+i];  // program sits at RESET_PC
        end
        repeat (6) @(posedge clock);
        #1 reset = 1'b0;

        while (!halt && cycles < cycle_limit) begin
            @(posedge clock);
            cycles = cycles + 1;
        end

        if (!halt) begin
            stop_on_error($sformatf("core never halted within %0d cycles", cycle_limit));
        end else begin
            check_value("store_count", word_t'(store_idx), word_t'(store_count));
            repeat (20) @(posedge clock);  // stay a while to catch late requests
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- verif/rv_core_vectors.txt
// header: program words, executed instructions, stores
// then program words from RESET_PC, then store records of addr wdata wmask
00000022 0000001F 0000000D
300017B7 FFB00093 00300113 002081B3 0037A023 40110233 0047A223 4010D293
0057A423 0020A333 0067A623 00001397 0077A823 00278AA3 00179B23 01678403
0087AC23 0167D483 0097AE23 0147A503 02A7A023 008005EF 0007A023 02B7A223
00208463 00500013 0207A423 00209463 0017A023 00000697 00C68667 0017A023
02C7A623 00100073
30001000 FFFFFFFE 0000000F
30001004 00000008 0000000F
30001008 FFFFFFFD 0000000F
3000100C 00000001 0000000F
30001010 3000102C 0000000F
30001015 00000300 00000002
30001016 FFFB0000 0000000C
30001018 FFFFFFFB 0000000F
3000101C 0000FFFB 0000000F
30001020 FFFB03EB 0000000F
30001024 30000058 0000000F
30001028 00000000 0000000F
3000102C 3000007C 0000000F

//--- src.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/inst_decoder.sv
rtl/execute_unit.sv
rtl/load_store_unit.sv
rtl/core_sequencer.sv
rtl/rv_core.sv
verif/tb_memory.sv
verif/rv_core_props.sv
verif/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
    -f src.f -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0
